// ==== compile.f ====
rtl/pcs_pkg.sv
rtl/pcs_tx_scrambler.sv
rtl/pcs_tx_seq_ctrl.sv
rtl/pcs_tx_gearbox.sv
rtl/pcs_tx_apb_regs.sv
rtl/pcs_tx_top.sv
verif/pcs_tx_tb.sv

// ==== rtl/pcs_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the 64b/66b PCS transmit path.
// Holds the block and word types, the gearbox sequence, the
// scrambler constants and the APB register map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pcs_pkg;

	localparam int PCS_HEAD_W  = 2;
	localparam int PCS_DATA_W  = 64;
	localparam int PCS_BLOCK_W = PCS_HEAD_W + PCS_DATA_W;
	// 2-bit lanes in one PMA word
	localparam int PCS_LANE_N  = PCS_DATA_W / PCS_HEAD_W;

	typedef logic [PCS_HEAD_W-1:0] pcs_head_t;
	typedef logic [PCS_DATA_W-1:0] pcs_data_t;

	// head goes out first on the stream, then data bit 0 upward
	typedef struct packed {
		pcs_head_t head;
		pcs_data_t data;
	} pcs_block_t;

	typedef logic [5:0] pcs_seq_t;
	localparam pcs_seq_t PCS_SEQ_FULL = pcs_seq_t'(PCS_LANE_N);

	// x^58 + x^39 + 1
	typedef logic [57:0] pcs_scr_state_t;
	localparam pcs_scr_state_t PCS_SCR_INIT = '1;
	localparam int PCS_SCR_TAP_A = 38;
	localparam int PCS_SCR_TAP_B = 57;

	// field order matches the register bits, bit 0 enable
	typedef struct packed {
		logic scr_bypass;
		logic enable;
	} pcs_ctrl_t;

	typedef logic [31:0] pcs_count_t;
	typedef logic [7:0]  apb_addr_t;

	localparam apb_addr_t REG_CTRL   = 8'h00;
	localparam apb_addr_t REG_BLOCKS = 8'h04;
	localparam apb_addr_t REG_SEQ    = 8'h08;

endpackage

`default_nettype wire

// ==== rtl/pcs_tx_apb_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB3 register block of the PCS transmit path.
// Control (enable, scrambler bypass), accepted-block counter
// and live gearbox sequence. Zero wait states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_apb_regs (
	input  wire                 clk,
	input  wire                 arst_n_i,
	input  wire                 psel_i,
	input  wire                 penable_i,
	input  wire                 pwrite_i,
	input  pcs_pkg::apb_addr_t  paddr_i,
	input  wire  [31:0]         pwdata_i,
	output logic [31:0]         prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,
	input  wire                 accept_i,
	input  pcs_pkg::pcs_seq_t   seq_i,
	output pcs_pkg::pcs_ctrl_t  ctrl_o
);
	import pcs_pkg::*;

	pcs_ctrl_t  ctrl_q;
	pcs_count_t blocks_q;

	logic access;
	logic hit_ctrl;
	logic hit_blocks;
	logic hit_seq;
	logic bad_access;
	logic wr_ctrl;

	assign access     = psel_i & penable_i;
	assign hit_ctrl   = (paddr_i == REG_CTRL);
	assign hit_blocks = (paddr_i == REG_BLOCKS);
	assign hit_seq    = (paddr_i == REG_SEQ);

	// unmapped, or write to a read-only register
	assign bad_access = ~(hit_ctrl | hit_blocks | hit_seq) | (pwrite_i & ~hit_ctrl);
	assign wr_ctrl    = access & pwrite_i & hit_ctrl;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q <= '0;
		end else if (wr_ctrl) begin
			ctrl_q <= pcs_ctrl_t'(pwdata_i[1:0]);
		end
	end

	// free-running, wraps at 2^32
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			blocks_q <= '0;
		end else if (accept_i) begin
			blocks_q <= blocks_q + pcs_count_t'(1);
		end
	end

	always_comb begin
		prdata_o = '0;
		if (access && !pwrite_i) begin
			if (hit_ctrl) begin
				prdata_o = {30'b0, ctrl_q};
			end else if (hit_blocks) begin
				prdata_o = blocks_q;
			end else if (hit_seq) begin
				prdata_o = {26'b0, seq_i};
			end
		end
	end

	assign pready_o  = access;
	assign pslverr_o = access & bad_access;
	assign ctrl_o    = ctrl_q;

endmodule

`default_nettype wire

// ==== rtl/pcs_tx_gearbox.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 66-to-64 gearbox for the transmit path.
// Packs accepted blocks into 64-bit PMA words; the leftover
// 2*seq bits wait in a remainder buffer. At seq 32 the full
// remainder goes out alone. Output is registered, 1 cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_gearbox (
	input  wire                 clk,
	input  wire                 arst_n_i,
	input  wire                 enable_i,
	input  pcs_pkg::pcs_seq_t   seq_i,
	input  wire                 accept_i,
	input  pcs_pkg::pcs_block_t block_i,
	output pcs_pkg::pcs_data_t  word_o,
	output logic                valid_o
);
	import pcs_pkg::*;

	localparam int SEQ_N = PCS_LANE_N + 1;

	// block in stream order, head in the low bits
	logic [PCS_BLOCK_W-1:0] blk_stream;

	pcs_data_t             wr_arr   [SEQ_N];
	pcs_data_t             rem_arr  [SEQ_N];
	logic [PCS_LANE_N-1:0] lane_arr [SEQ_N];

	pcs_data_t             wr_sel;
	pcs_data_t             rem_sel;
	logic [PCS_LANE_N-1:0] lane_sel;
	pcs_data_t             rd_mask;

	pcs_data_t rem_q;
	pcs_data_t word_next;
	pcs_data_t word_q;
	logic      valid_q;
	logic      load;

	assign blk_stream = {block_i.data, block_i.head};

	// one shift/mask set per sequence value
	for (genvar s = 0; s < SEQ_N; s++) begin : g_seq
		if (s < PCS_LANE_N) begin : g_fill
			// new block lands above the 2*s remainder bits
			assign wr_arr[s]  = pcs_data_t'(blk_stream << (PCS_HEAD_W * s));
			// top 2*s+2 bits of the block carry over
			assign rem_arr[s] = pcs_data_t'(blk_stream >> (PCS_DATA_W - PCS_HEAD_W * s));
		end else begin : g_drain
			assign wr_arr[s]  = '0;
			assign rem_arr[s] = '0;
		end
		// lanes below s belong to the remainder
		for (genvar l = 0; l < PCS_LANE_N; l++) begin : g_lane
			assign lane_arr[s][l] = (l < s) ? 1'b1 : 1'b0;
		end
	end

	always_comb begin
		wr_sel   = '0;
		rem_sel  = '0;
		lane_sel = '0;
		for (int k = 0; k < SEQ_N; k++) begin
			if (seq_i == pcs_seq_t'(k)) begin
				wr_sel   = wr_arr[k];
				rem_sel  = rem_arr[k];
				lane_sel = lane_arr[k];
			end
		end
	end

	// widen the lane mask to bits
	for (genvar l = 0; l < PCS_LANE_N; l++) begin : g_mask
		assign rd_mask[l*PCS_HEAD_W +: PCS_HEAD_W] = {PCS_HEAD_W{lane_sel[l]}};
	end

	assign word_next = (rd_mask & rem_q) | (~rd_mask & wr_sel);

	// a word leaves on every accept and on the drain cycle
	assign load = enable_i & (accept_i | (seq_i == PCS_SEQ_FULL));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rem_q   <= '0;
			word_q  <= '0;
			valid_q <= 1'b0;
		end else if (!enable_i) begin
			// leftover bits are dropped on disable
			rem_q   <= '0;
			valid_q <= 1'b0;
		end else if (load) begin
			rem_q   <= rem_sel;
			word_q  <= word_next;
			valid_q <= 1'b1;
		end else begin
			valid_q <= 1'b0;
		end
	end

	assign word_o  = word_q;
	assign valid_o = valid_q;

endmodule

`default_nettype wire

// ==== rtl/pcs_tx_scrambler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-synchronous scrambler for the 64-bit block payload.
// Combinational on the data path, the state steps on accept.
// The sync header passes through untouched.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_scrambler (
	input  wire                 clk,
	input  wire                 arst_n_i,
	input  wire                 bypass_i,
	input  wire                 accept_i,
	input  pcs_pkg::pcs_block_t block_i,
	output pcs_pkg::pcs_block_t block_o
);
	import pcs_pkg::*;

	pcs_scr_state_t scr_q;
	pcs_scr_state_t scr_d;
	pcs_data_t      data_scr;

	// serial model unrolled over the payload, lsb first
	always_comb begin
		logic           bit_v;
		pcs_scr_state_t state_v;
		state_v  = scr_q;
		data_scr = '0;
		for (int i = 0; i < PCS_DATA_W; i++) begin
			bit_v = block_i.data[i];
			if (!bypass_i) begin
				bit_v = bit_v ^ state_v[PCS_SCR_TAP_A] ^ state_v[PCS_SCR_TAP_B];
			end
			data_scr[i] = bit_v;
			// state always fed with the bit that leaves
			state_v = {state_v[56:0], bit_v};
		end
		scr_d = state_v;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scr_q <= PCS_SCR_INIT;
		end else if (accept_i) begin
			scr_q <= scr_d;
		end
	end

	assign block_o.head = block_i.head;
	assign block_o.data = data_scr;

endmodule

`default_nettype wire

// ==== rtl/pcs_tx_seq_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gearbox sequence counter and MAC-side flow control.
// Counts 0 to 32 while enabled and holds ready low at 32 so
// the gearbox can drain its remainder.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_seq_ctrl (
	input  wire               clk,
	input  wire               arst_n_i,
	input  wire               enable_i,
	output pcs_pkg::pcs_seq_t seq_o,
	output logic              tx_ready_o,
	output logic              accept_o
);
	import pcs_pkg::*;

	pcs_seq_t seq_q;
	logic     seq_full;

	assign seq_full = (seq_q == PCS_SEQ_FULL);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			seq_q <= '0;
		end else if (!enable_i) begin
			// disable restarts the block framing
			seq_q <= '0;
		end else if (seq_full) begin
			seq_q <= '0;
		end else begin
			seq_q <= seq_q + pcs_seq_t'(1);
		end
	end

	// source always has a block, so ready alone decides acceptance
	assign tx_ready_o = enable_i & ~seq_full;
	assign accept_o   = tx_ready_o;
	assign seq_o      = seq_q;

endmodule

`default_nettype wire

// ==== rtl/pcs_tx_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the 64b/66b PCS transmit path.
// MAC blocks in, scrambled and geared to 64-bit PMA words out,
// controlled and observed over APB.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_top (
	input  wire                 clk,
	input  wire                 arst_n_i,
	// APB slave
	input  wire                 psel_i,
	input  wire                 penable_i,
	input  wire                 pwrite_i,
	input  pcs_pkg::apb_addr_t  paddr_i,
	input  wire  [31:0]         pwdata_i,
	output logic [31:0]         prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,
	// MAC side
	input  pcs_pkg::pcs_block_t tx_block_i,
	output logic                tx_ready_o,
	// PMA side
	output pcs_pkg::pcs_data_t  pma_word_o,
	output logic                pma_valid_o
);
	import pcs_pkg::*;

	pcs_ctrl_t  ctrl;
	pcs_seq_t   seq;
	logic       accept;
	pcs_block_t scr_block;

	pcs_tx_apb_regs u_regs (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.accept_i  (accept),
		.seq_i     (seq),
		.ctrl_o    (ctrl)
	);

	pcs_tx_seq_ctrl u_seq (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.enable_i   (ctrl.enable),
		.seq_o      (seq),
		.tx_ready_o (tx_ready_o),
		.accept_o   (accept)
	);

	pcs_tx_scrambler u_scr (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.bypass_i (ctrl.scr_bypass),
		.accept_i (accept),
		.block_i  (tx_block_i),
		.block_o  (scr_block)
	);

	pcs_tx_gearbox u_gbx (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.enable_i (ctrl.enable),
		.seq_i    (seq),
		.accept_i (accept),
		.block_i  (scr_block),
		.word_o   (pma_word_o),
		.valid_o  (pma_valid_o)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the PCS transmit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module pcs_tx_tb -f compile.f -o pcs_tx_sim \
	&& ./obj_dir/pcs_tx_sim > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log && echo "result: pass" && exit 0 \
	|| { echo "result: fail"; exit 1; }

// ==== verif/pcs_tx_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the 64b/66b PCS transmit path.
// Random blocks go in whenever ready is high. PMA words are
// compared with a bit-stream model of scrambler and gearbox.
// APB transfers cover control, block count and error responses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_tb;
	import pcs_pkg::*;

	localparam int WAIT_MAX = 50;

	logic           clk;
	logic           arst_n_i;
	logic           psel;
	logic           penable;
	logic           pwrite;
	apb_addr_t      paddr;
	logic [31:0]    pwdata;
	logic [31:0]    prdata;
	logic           pready;
	logic           pslverr;
	pcs_block_t     tx_block;
	logic           tx_ready;
	pcs_data_t      pma_word;
	logic           pma_valid;

	// model state
	pcs_ctrl_t      ctrl_model;
	pcs_scr_state_t scr_hist;
	bit             stream_q [$];
	pcs_data_t      exp_q [$];
	logic [31:0]    rd_data;
	logic           rd_err;
	int             accepted;
	int             errors;
	int             tests;
	int             failed;

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	pcs_tx_top u_dut (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.psel_i      (psel),
		.penable_i   (penable),
		.pwrite_i    (pwrite),
		.paddr_i     (paddr),
		.pwdata_i    (pwdata),
		.prdata_o    (prdata),
		.pready_o    (pready),
		.pslverr_o   (pslverr),
		.tx_block_i  (tx_block),
		.tx_ready_o  (tx_ready),
		.pma_word_o  (pma_word),
		.pma_valid_o (pma_valid)
	);

	task automatic check_word(input string name, input pcs_data_t got, input pcs_data_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_seq(input string name, input pcs_seq_t got, input pcs_seq_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input pcs_count_t got, input pcs_count_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_ctrl(input string name, input pcs_ctrl_t got, input pcs_ctrl_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// each output bit is the input bit xor the scrambled bits
	// sent 39 and 58 bit times earlier; hist[0] is the oldest
	function automatic pcs_data_t scramble_ref(input pcs_data_t din, input logic bypass);
		logic [121:0] hist;
		pcs_data_t    dout;
		hist = {64'b0, scr_hist};
		for (int i = 0; i < 64; i++) begin
			if (bypass) begin
				hist[58 + i] = din[i];
			end else begin
				hist[58 + i] = din[i] ^ hist[19 + i] ^ hist[i];
			end
			dout[i] = hist[58 + i];
		end
		scr_hist = hist[121:64];
		return dout;
	endfunction

	// append one block in stream order and pop every full word
	task automatic push_block(input pcs_block_t blk);
		pcs_data_t d;
		pcs_data_t w;
		d = scramble_ref(blk.data, ctrl_model.scr_bypass);
		stream_q.push_back(blk.head[0]);
		stream_q.push_back(blk.head[1]);
		for (int i = 0; i < 64; i++) begin
			stream_q.push_back(d[i]);
		end
		while (stream_q.size() >= 64) begin
			for (int i = 0; i < 64; i++) begin
				w[i] = stream_q.pop_front();
			end
			exp_q.push_back(w);
		end
		accepted++;
	endtask

	task automatic abort_run(input string why);
		$display("error: %s", why);
		$display("FAIL: see errors above");
		$finish;
	endtask

	// one APB transfer with data and error sampled before the access edge
	task automatic apb_xfer(input logic write, input apb_addr_t addr, input logic [31:0] wdata);
		int waited;
		waited = 0;
		@(negedge clk);
		psel   = 1'b1;
		pwrite = write;
		paddr  = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (pready !== 1'b1 && waited < WAIT_MAX) begin
			waited++;
			@(negedge clk);
			#1;
		end
		if (pready !== 1'b1) begin
			abort_run($sformatf("no pready from the APB slave at address %h", addr));
		end
		rd_data = prdata;
		rd_err  = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_MAX) begin
			waited++;
			@(posedge clk);
		end
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d expected PMA words never came out", exp_q.size()));
		end
	endtask

	task automatic report_test(input int num, input string what, input int mark);
		if (errors == mark) begin
			$display("test %0d %s: ok", num, what);
		end else begin
			$display("test %0d %s: %0d errors", num, what, errors - mark);
			failed++;
		end
		tests++;
	endtask

	// control register model that updates on the access edge
	initial begin
		ctrl_model = '0;
		forever begin
			@(posedge clk);
			if (psel && penable && pwrite && paddr == REG_CTRL) begin
				ctrl_model = pcs_ctrl_t'(pwdata[1:0]);
			end
		end
	end

	// block source and word compare on the falling edge
	initial begin
		void'($urandom(32'h1b8b7e2c));
		tx_block = '0;
		scr_hist = '1;
		forever begin
			@(negedge clk);
			if (pma_valid) begin
				if (exp_q.size() == 0) begin
					$display("error: PMA word %h with no expected word pending", pma_word);
					errors++;
				end else begin
					check_word("pma_word_o", pma_word, exp_q.pop_front());
				end
			end
			if (!ctrl_model.enable) begin
				stream_q.delete();
			end
			if (tx_ready) begin
				tx_block.head = pcs_head_t'($urandom);
				tx_block.data = {$urandom, $urandom};
				push_block(tx_block);
			end
		end
	end

	initial begin
		int mark;
		arst_n_i = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		accepted = 0;
		errors   = 0;
		tests    = 0;
		failed   = 0;
		repeat (5) @(negedge clk);
		arst_n_i = 1'b1;

		mark = errors;
		check_flag("tx_ready_o", tx_ready, 1'b0);
		check_flag("pma_valid_o", pma_valid, 1'b0);
		apb_xfer(1'b0, REG_CTRL, '0);
		check_ctrl("REG_CTRL", pcs_ctrl_t'(rd_data[1:0]), '0);
		apb_xfer(1'b0, REG_BLOCKS, '0);
		check_count("REG_BLOCKS", rd_data, '0);
		report_test(1, "reset state", mark);

		// 32 ready cycles and one drain cycle per sequence
		mark = errors;
		apb_xfer(1'b1, REG_CTRL, 32'h3);
		for (int i = 0; i < 99; i++) begin
			check_flag("tx_ready_o", tx_ready, (i % 33) != 32);
			@(negedge clk);
		end
		report_test(2, "bypass stream and ready pattern", mark);

		mark = errors;
		apb_xfer(1'b1, REG_CTRL, 32'h1);
		repeat (200) @(negedge clk);
		apb_xfer(1'b1, REG_CTRL, 32'h0);
		wait_drain();
		report_test(3, "scrambled stream", mark);

		mark = errors;
		apb_xfer(1'b0, REG_BLOCKS, '0);
		check_count("REG_BLOCKS", rd_data, pcs_count_t'(accepted));
		apb_xfer(1'b0, REG_SEQ, '0);
		check_seq("REG_SEQ", pcs_seq_t'(rd_data[5:0]), '0);
		report_test(4, "block count and idle sequence", mark);

		// restart partway through a sequence
		mark = errors;
		apb_xfer(1'b1, REG_CTRL, 32'h1);
		repeat (45) @(negedge clk);
		apb_xfer(1'b1, REG_CTRL, 32'h0);
		apb_xfer(1'b1, REG_CTRL, 32'h1);
		repeat (70) @(negedge clk);
		apb_xfer(1'b1, REG_CTRL, 32'h2);
		wait_drain();
		report_test(5, "disable and re-enable", mark);

		mark = errors;
		apb_xfer(1'b1, REG_BLOCKS, 32'h59);
		check_flag("pslverr_o", rd_err, 1'b1);
		apb_xfer(1'b0, 8'h10, '0);
		check_flag("pslverr_o", rd_err, 1'b1);
		apb_xfer(1'b0, REG_CTRL, '0);
		check_flag("pslverr_o", rd_err, 1'b0);
		check_ctrl("REG_CTRL", pcs_ctrl_t'(rd_data[1:0]), pcs_ctrl_t'(2'b10));
		apb_xfer(1'b0, REG_BLOCKS, '0);
		check_count("REG_BLOCKS", rd_data, pcs_count_t'(accepted));
		report_test(6, "APB error responses", mark);

		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
